//--- hdl/uart_pkg.sv
/*
 * Shared definitions for the UART: address map, widths and the layout of the
 * control/status and data words. Modules take it by wildcard import.
 */
package uart_pkg;

    // address map --------------------------------------------------------
    localparam logic [31:0] uart_base_c      = 32'hffff_ffa0; // register pair base
    localparam logic [31:0] uart_ctrl_addr_c = uart_base_c + 32'd0; // control/status
    localparam logic [31:0] uart_rtx_addr_c  = uart_base_c + 32'd4; // rx/tx data

    // widths and frame lengths -------------------------------------------
    localparam int unsigned data_w_c   = 8;  // character width
    localparam int unsigned baud_w_c   = 10; // baud divisor
    localparam int unsigned prsc_w_c   = 3;  // prescaler select
    localparam int unsigned clkgen_w_c = 8;  // prescaler tap bus
    localparam int unsigned tx_bits_c  = 11; // start + 8 data + stop + pause
    localparam int unsigned rx_bits_c  = 10; // start + 8 data + stop

    // control/status layout, msb first
    typedef struct packed {
        logic                tx_busy;   // 31
        logic                rx_over;   // 30
        logic [2:0]          rsvd_hi;   // 29..27
        logic [4:0]          irq_en;    // 26..22, same order as 20..16
        logic                tx_full;   // 21
        logic                tx_nhalf;  // 20
        logic                tx_empty;  // 19
        logic                rx_full;   // 18
        logic                rx_half;   // 17
        logic                rx_nempty; // 16
        logic [baud_w_c-1:0] baud;      // 15..6
        logic [prsc_w_c-1:0] prsc;      // 5..3
        logic                hwfc_en;   // 2
        logic                rsvd_lo;   // 1, formerly sim mode
        logic                enable;    // 0
    } ctrl_word_t;

    typedef struct packed {
        logic [31-data_w_c:0] zero; // always reads zero
        logic [data_w_c-1:0]  data; // received byte / byte to send
    } rtx_word_t;

    // one bus word, decoded by address
    typedef union packed {
        ctrl_word_t ctrl;
        rtx_word_t  rtx;
    } bus_word_u;

endpackage

//--- hdl/uart_fifo.sv
/*
 * Byte FIFO with synchronous read register and clear, used for RX and TX.
 * Writes when full and reads when empty are ignored.
 */
module uart_fifo #(
    parameter int DEPTH = 4 // power of two, min 1
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          clear_i,
    input  logic                          we_i,
    input  logic [uart_pkg::data_w_c-1:0] wdata_i,
    input  logic                          re_i,
    output logic [uart_pkg::data_w_c-1:0] rdata_o,
    output logic                          free_o,
    output logic                          avail_o,
    output logic                          half_o
);
    localparam int lw_c   = $clog2(DEPTH) + 1;              // level counter width
    localparam int iw_c   = (DEPTH > 1) ? $clog2(DEPTH) : 1; // index width
    localparam int half_c = (DEPTH > 1) ? DEPTH / 2 : 1;     // depth 1 -> full

    logic [uart_pkg::data_w_c-1:0] mem [DEPTH];
    logic [iw_c-1:0]               w_idx, r_idx;
    logic [lw_c-1:0]               lvl;   // entries stored
    logic                          we_ok, re_ok;

    if ((DEPTH < 1) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
        $error("uart fifo depth has to be a power of two");
    end

    assign we_ok   = we_i & free_o;
    assign re_ok   = re_i & avail_o;
    assign free_o  = (lvl != lw_c'(DEPTH));
    assign avail_o = (lvl != '0);
    assign half_o  = (lvl >= lw_c'(half_c));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            w_idx <= '0;
            r_idx <= '0;
            lvl   <= '0;
        end else if (clear_i) begin
            w_idx <= '0;
            r_idx <= '0;
            lvl   <= '0;
        end else begin
            if (we_ok) w_idx <= (w_idx == iw_c'(DEPTH - 1)) ? '0 : w_idx + 1'b1;
            if (re_ok) r_idx <= (r_idx == iw_c'(DEPTH - 1)) ? '0 : r_idx + 1'b1;
            case ({we_ok, re_ok})
                2'b10:   lvl <= lvl + 1'b1;
                2'b01:   lvl <= lvl - 1'b1;
                default: lvl <= lvl; // both or none
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_ok) mem[w_idx] <= wdata_i;
        if (re_ok) rdata_o <= mem[r_idx]; // held until next pop
    end

    a_level : assert property (@(posedge clk_i) disable iff (!rstn_i) lvl <= DEPTH);

endmodule

//--- hdl/uart_regs.sv
/*
 * Register block: decodes the two word addresses, holds the control register,
 * forms the FIFO strobes and returns the read word two cycles after a read.
 */
module uart_regs (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [31:0]                   addr_i,
    input  logic                          rden_i,
    input  logic                          wren_i,
    input  logic [31:0]                   data_i,
    output logic [31:0]                   data_o,
    output logic                          ack_o,
    input  logic [uart_pkg::clkgen_w_c-1:0] clkgen_i,
    input  logic                          tx_free_i,
    input  logic                          tx_avail_i,
    input  logic                          tx_half_i,
    input  logic                          tx_busy_i,
    input  logic                          rx_free_i,
    input  logic                          rx_avail_i,
    input  logic                          rx_half_i,
    input  logic [uart_pkg::data_w_c-1:0] rx_rdata_i,
    input  logic                          rx_over_i,
    output logic                          clkgen_en_o,
    output logic                          enable_o,
    output logic                          hwfc_en_o,
    output logic [uart_pkg::baud_w_c-1:0] baud_o,
    output logic                          tick_o,
    output logic [4:0]                    irq_en_o,
    output logic                          tx_we_o,
    output logic [uart_pkg::data_w_c-1:0] tx_wdata_o,
    output logic                          rx_re_o
);
    import uart_pkg::*;

    logic                is_ctrl, is_rtx; // word address hits
    logic                wren, rden;      // decoded strobes
    logic                rden_ff;         // read pending, fifo data arrives
    logic                rd_ctrl_ff;      // pending read targets ctrl
    logic                enable_q, hwfc_q;
    logic [prsc_w_c-1:0] prsc_q;
    logic [baud_w_c-1:0] baud_q;
    logic [4:0]          irq_en_q;
    bus_word_u           wr_word, rd_word;

    // decode ----------------------------------------------------
    assign is_ctrl = (addr_i[31:2] == uart_ctrl_addr_c[31:2]);
    assign is_rtx  = (addr_i[31:2] == uart_rtx_addr_c[31:2]);
    assign wren    = wren_i & (is_ctrl | is_rtx);
    assign rden    = rden_i & (is_ctrl | is_rtx);
    assign wr_word = data_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_q <= 1'b0;
            hwfc_q   <= 1'b0;
            prsc_q   <= '0;
            baud_q   <= '0;
            irq_en_q <= '0;
        end else if (wren_i && is_ctrl) begin
            enable_q <= wr_word.ctrl.enable;
            hwfc_q   <= wr_word.ctrl.hwfc_en;
            prsc_q   <= wr_word.ctrl.prsc;
            baud_q   <= wr_word.ctrl.baud;
            irq_en_q <= wr_word.ctrl.irq_en;
        end
    end

    assign enable_o    = enable_q;
    assign clkgen_en_o = enable_q;         // prescaler runs only when enabled
    assign tick_o      = clkgen_i[prsc_q]; // selected tap is the bit tick
    assign hwfc_en_o   = hwfc_q;
    assign baud_o      = baud_q;
    assign irq_en_o    = irq_en_q;
    assign tx_we_o     = wren_i & is_rtx;
    assign tx_wdata_o  = wr_word.rtx.data;
    assign rx_re_o     = rden_i & is_rtx; // pop, data valid next cycle

    // read word ---------------------------------------------------
    always_comb begin
        rd_word = '0;
        if (rd_ctrl_ff) begin
            rd_word.ctrl.enable    = enable_q;
            rd_word.ctrl.hwfc_en   = hwfc_q;
            rd_word.ctrl.prsc      = prsc_q;
            rd_word.ctrl.baud      = baud_q;
            rd_word.ctrl.rx_nempty = rx_avail_i;
            rd_word.ctrl.rx_half   = rx_half_i;
            rd_word.ctrl.rx_full   = ~rx_free_i;
            rd_word.ctrl.tx_empty  = ~tx_avail_i;
            rd_word.ctrl.tx_nhalf  = ~tx_half_i;
            rd_word.ctrl.tx_full   = ~tx_free_i;
            rd_word.ctrl.irq_en    = irq_en_q;
            rd_word.ctrl.rx_over   = rx_over_i;
            rd_word.ctrl.tx_busy   = tx_busy_i | tx_avail_i; // engine or queue busy
        end else begin
            rd_word.rtx.data = rx_rdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rden_ff    <= 1'b0;
            rd_ctrl_ff <= 1'b0;
            ack_o      <= 1'b0;
            data_o     <= '0;
        end else begin
            rden_ff    <= rden;
            rd_ctrl_ff <= is_ctrl;
            ack_o      <= wren | rden_ff; // write +1, read +2
            data_o     <= rden_ff ? rd_word : '0;
        end
    end

    // a push while enabled is acknowledged and lands in the tx fifo
    a_tx_we_ack : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (tx_we_o && enable_q) |=> (ack_o && tx_avail_i));
    // a pop returns two cycles later in the data layout
    a_rx_re_ack : assert property (@(posedge clk_i) disable iff (!rstn_i)
        rx_re_o |=> ##1 (ack_o && (data_o[31:data_w_c] == '0)));

endmodule

//--- hdl/uart_tx.sv
/*
 * Transmit engine: idle, prepare and send states. Pops one byte from the TX
 * FIFO, waits for CTS under flow control and shifts the frame out LSB first.
 */
module uart_tx (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          enable_i,
    input  logic                          hwfc_en_i,
    input  logic [uart_pkg::baud_w_c-1:0] baud_i,
    input  logic                          tick_i,
    input  logic                          avail_i,
    input  logic [uart_pkg::data_w_c-1:0] rdata_i,
    input  logic                          uart_cts_i,
    output logic                          re_o,
    output logic                          busy_o,
    output logic                          uart_txd_o
);
    import uart_pkg::*;

    localparam int         cnt_w_c   = $clog2(tx_bits_c + 1);
    localparam logic [1:0] st_idle_c = 2'b00;
    localparam logic [1:0] st_prep_c = 2'b01;
    localparam logic [1:0] st_send_c = 2'b11;

    logic [1:0]          state_q;
    logic [1:0]          cts_sync;  // two-stage, active low
    logic [baud_w_c-1:0] baudcnt;
    logic [cnt_w_c-1:0]  bitcnt;
    logic [data_w_c:0]   sreg;      // data + start bit

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= st_idle_c;
            cts_sync <= 2'b11;
        end else begin
            cts_sync <= {cts_sync[0], uart_cts_i};
            case (state_q)
                st_idle_c: begin
                    baudcnt <= baud_i;
                    bitcnt  <= cnt_w_c'(tx_bits_c);
                    if (avail_i) state_q <= st_prep_c;
                end
                st_prep_c: begin
                    sreg <= {rdata_i, 1'b0}; // popped byte is valid now
                    if (!cts_sync[1] || !hwfc_en_i) state_q <= st_send_c;
                end
                st_send_c: begin
                    if (tick_i) begin
                        if (baudcnt == '0) begin // bit done
                            baudcnt <= baud_i;
                            bitcnt  <= bitcnt - 1'b1;
                            sreg    <= {1'b1, sreg[data_w_c:1]}; // fill with stop/pause
                        end else begin
                            baudcnt <= baudcnt - 1'b1;
                        end
                    end
                    if (bitcnt == '0) state_q <= st_idle_c;
                end
                default: state_q <= st_idle_c;
            endcase
            if (!enable_i) state_q <= st_idle_c; // disable aborts the frame
        end
    end

    assign re_o       = (state_q == st_idle_c) & avail_i & enable_i;
    assign busy_o     = (state_q != st_idle_c);
    assign uart_txd_o = (state_q == st_send_c) ? sreg[0] : 1'b1; // idles high

    // stop and pause bits keep the line high
    a_line_stop : assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((state_q == st_send_c) && (bitcnt < 3)) |-> uart_txd_o);

endmodule

//--- hdl/uart_rx.sv
/*
 * Receive engine: synchronizes the line, detects the start edge and samples
 * ten bits in the middle of each bit time. done_o pulses with a valid byte.
 */
module uart_rx (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          enable_i,
    input  logic [uart_pkg::baud_w_c-1:0] baud_i,
    input  logic                          tick_i,
    input  logic                          uart_rxd_i,
    output logic                          done_o,
    output logic [uart_pkg::data_w_c-1:0] byte_o
);
    import uart_pkg::*;

    localparam int cnt_w_c = $clog2(rx_bits_c + 1);

    logic                 busy_q;   // receiving a frame
    logic                 done_q;
    logic [2:0]           sync;     // [2] newest, [1:0] on ticks
    logic [baud_w_c-1:0]  baudcnt;
    logic [cnt_w_c-1:0]   bitcnt;
    logic [rx_bits_c-1:0] sreg;     // stop, data, start

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            sync   <= 3'b111; // line idles high
        end else begin
            sync[2] <= uart_rxd_i;
            if (tick_i) begin
                sync[1] <= sync[2];
                sync[0] <= sync[1];
            end
            done_q <= 1'b0;

            if (!busy_q) begin
                baudcnt <= {1'b0, baud_i[baud_w_c-1:1]}; // half bit to mid-sample
                bitcnt  <= cnt_w_c'(rx_bits_c);
                if (sync[1:0] == 2'b01) busy_q <= 1'b1; // falling edge = start
            end else begin
                if (tick_i) begin
                    if (baudcnt == '0) begin // sample point
                        baudcnt <= baud_i;
                        bitcnt  <= bitcnt - 1'b1;
                        sreg    <= {sync[2], sreg[rx_bits_c-1:1]};
                    end else begin
                        baudcnt <= baudcnt - 1'b1;
                    end
                end
                if (bitcnt == '0) begin // all ten bits in
                    done_q <= 1'b1;
                    busy_q <= 1'b0;
                end
            end

            if (!enable_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b0;
            end
        end
    end

    assign done_o = done_q;
    assign byte_o = sreg[data_w_c:1]; // drop start and stop

    a_done_pulse : assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_o |=> !done_o);

endmodule

//--- hdl/uart_status.sv
/*
 * Status logic: registered RX/TX interrupts from FIFO levels, RTS under
 * flow control and the sticky RX overrun flag.
 */
module uart_status (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       enable_i,
    input  logic       hwfc_en_i,
    input  logic [4:0] irq_en_i,  // rx nempty/half/full, tx empty/nhalf
    input  logic       rx_done_i,
    input  logic       rx_re_i,
    input  logic       rx_free_i,
    input  logic       rx_avail_i,
    input  logic       rx_half_i,
    input  logic       tx_avail_i,
    input  logic       tx_half_i,
    output logic       irq_rx_o,
    output logic       irq_tx_o,
    output logic       uart_rts_o,
    output logic       rx_over_o
);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            irq_rx_o   <= 1'b0;
            irq_tx_o   <= 1'b0;
            uart_rts_o <= 1'b0;
            rx_over_o  <= 1'b0;
        end else begin
            irq_rx_o <= enable_i & ((irq_en_i[0] & rx_avail_i) |
                                    (irq_en_i[1] & rx_half_i)  |
                                    (irq_en_i[2] & ~rx_free_i));
            irq_tx_o <= enable_i & ((irq_en_i[3] & ~tx_avail_i) |
                                    (irq_en_i[4] & ~tx_half_i));
            // stop the remote side while disabled or short of space
            uart_rts_o <= hwfc_en_i & (~enable_i | rx_half_i);
            if (rx_re_i || !enable_i) begin
                rx_over_o <= 1'b0; // data read or disable clears
            end else if (rx_done_i && !rx_free_i) begin
                rx_over_o <= 1'b1; // byte lost at full fifo
            end
        end
    end

endmodule

//--- hdl/uart_top.sv
/*
 * UART top level: register block, TX/RX FIFOs, bit engines and status logic.
 * FIFO depths are set here and passed down.
 */
module uart_top #(
    parameter int RX_FIFO_DEPTH = 4, // power of two, min 1
    parameter int TX_FIFO_DEPTH = 4  // power of two, min 1
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [31:0]                     addr_i,
    input  logic                            rden_i,
    input  logic                            wren_i,
    input  logic [31:0]                     data_i,
    output logic [31:0]                     data_o,
    output logic                            ack_o,
    output logic                            clkgen_en_o,
    input  logic [uart_pkg::clkgen_w_c-1:0] clkgen_i,
    output logic                            uart_txd_o,
    input  logic                            uart_rxd_i,
    output logic                            uart_rts_o,
    input  logic                            uart_cts_i,
    output logic                            irq_rx_o,
    output logic                            irq_tx_o
);
    import uart_pkg::*;

    logic                enable, hwfc_en, tick, rx_over;
    logic [baud_w_c-1:0] baud;
    logic [4:0]          irq_en;
    logic                tx_we, tx_re, tx_busy, tx_free, tx_avail, tx_half;
    logic                rx_re, rx_done, rx_free, rx_avail, rx_half;
    logic [data_w_c-1:0] tx_wdata, tx_rdata, rx_byte, rx_rdata;

    uart_regs regs_inst (
        .clk_i, .rstn_i, .addr_i, .rden_i, .wren_i, .data_i, .data_o, .ack_o,
        .clkgen_i, .clkgen_en_o,
        .tx_free_i (tx_free), .tx_avail_i (tx_avail), .tx_half_i (tx_half),
        .tx_busy_i (tx_busy), .rx_free_i (rx_free), .rx_avail_i (rx_avail),
        .rx_half_i (rx_half), .rx_rdata_i (rx_rdata), .rx_over_i (rx_over),
        .enable_o (enable), .hwfc_en_o (hwfc_en), .baud_o (baud), .tick_o (tick),
        .irq_en_o (irq_en), .tx_we_o (tx_we), .tx_wdata_o (tx_wdata), .rx_re_o (rx_re)
    );

    // data buffers, cleared while disabled ---------------------
    uart_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo_inst (
        .clk_i, .rstn_i, .clear_i (~enable), .we_i (tx_we), .wdata_i (tx_wdata),
        .re_i (tx_re), .rdata_o (tx_rdata), .free_o (tx_free), .avail_o (tx_avail),
        .half_o (tx_half)
    );

    uart_fifo #(.DEPTH(RX_FIFO_DEPTH)) rx_fifo_inst (
        .clk_i, .rstn_i, .clear_i (~enable), .we_i (rx_done), .wdata_i (rx_byte),
        .re_i (rx_re), .rdata_o (rx_rdata), .free_o (rx_free), .avail_o (rx_avail),
        .half_o (rx_half)
    );

    uart_tx tx_inst (
        .clk_i, .rstn_i, .enable_i (enable), .hwfc_en_i (hwfc_en), .baud_i (baud),
        .tick_i (tick), .avail_i (tx_avail), .rdata_i (tx_rdata), .uart_cts_i,
        .re_o (tx_re), .busy_o (tx_busy), .uart_txd_o
    );

    uart_rx rx_inst (
        .clk_i, .rstn_i, .enable_i (enable), .baud_i (baud), .tick_i (tick),
        .uart_rxd_i, .done_o (rx_done), .byte_o (rx_byte)
    );

    uart_status status_inst (
        .clk_i, .rstn_i, .enable_i (enable), .hwfc_en_i (hwfc_en), .irq_en_i (irq_en),
        .rx_done_i (rx_done), .rx_re_i (rx_re), .rx_free_i (rx_free),
        .rx_avail_i (rx_avail), .rx_half_i (rx_half), .tx_avail_i (tx_avail),
        .tx_half_i (tx_half), .irq_rx_o, .irq_tx_o, .uart_rts_o, .rx_over_o (rx_over)
    );

endmodule

//--- testbench/tb_uart.sv
/*
 * Self-checking testbench for the UART top level. It drives the bus and serial
 * lines with LFSR data and checks the results against a bus and line model.
 */
module tb_uart;
    import uart_pkg::*;

    localparam int          depth_c      = 4;            // both fifos
    localparam int          baud_c       = 7;
    localparam int          bit_cyc_c    = baud_c + 1;   // cycles per bit, tick every cycle
    localparam int          tmo_c        = 2000;         // cycles or polls per wait
    localparam int          sel_irq_rx_c = 0;
    localparam int          sel_irq_tx_c = 1;
    localparam int          sel_rts_c    = 2;
    localparam logic [31:0] m_rx_nempty_c = 32'h0001_0000; // status bit 16
    localparam logic [31:0] m_rx_over_c   = 32'h4000_0000; // status bit 30
    localparam logic [31:0] m_tx_busy_c   = 32'h8000_0000; // status bit 31

    logic        clk_i, rstn_i;
    logic [31:0] addr_i, data_i, data_o;
    logic        rden_i, wren_i, ack_o;
    logic        clkgen_en_o;
    logic [7:0]  clkgen_i;
    logic        uart_txd_o, uart_rxd_i, uart_rts_o, uart_cts_i;
    logic        irq_rx_o, irq_tx_o;
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    uart_top #(.RX_FIFO_DEPTH(depth_c), .TX_FIFO_DEPTH(depth_c)) UUT (
        .clk_i, .rstn_i, .addr_i, .rden_i, .wren_i, .data_i, .data_o, .ack_o,
        .clkgen_en_o, .clkgen_i, .uart_txd_o, .uart_rxd_i, .uart_rts_o, .uart_cts_i,
        .irq_rx_o, .irq_tx_o
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // helpers ----------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003; // galois taps 32,22,2,1
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic line_level(input int sel);
        case (sel)
            sel_irq_rx_c: return irq_rx_o;
            sel_irq_tx_c: return irq_tx_o;
            default:      return uart_rts_o;
        endcase
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1; // drive away from the edge
    endtask

    // bus access -------------------------------------------------
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] value);
        int lat;
        addr_i = addr;
        data_i = value;
        wren_i = 1'b1;
        next_cycle();
        wren_i = 1'b0;
        lat    = 1;
        while (!ack_o) begin
            next_cycle();
            lat++;
            if (lat > tmo_c) abort_on_timeout("write acknowledge");
        end
        check("write ack latency", 1, lat);
        check("data_o outside read", 32'h0, data_o);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] value);
        int lat;
        addr_i = addr;
        rden_i = 1'b1;
        next_cycle();
        rden_i = 1'b0;
        lat    = 1;
        while (!ack_o) begin
            next_cycle();
            lat++;
            if (lat > tmo_c) abort_on_timeout("read acknowledge");
        end
        value = data_o;
        check("read ack latency", 2, lat); // fifo read is registered
    endtask

    task automatic write_ctrl(input logic en, input logic hwfc, input logic [2:0] prsc,
                              input logic [9:0] baud, input logic [4:0] irq_en);
        bus_word_u w;
        w              = '0;
        w.ctrl.enable  = en;
        w.ctrl.hwfc_en = hwfc;
        w.ctrl.prsc    = prsc;
        w.ctrl.baud    = baud;
        w.ctrl.irq_en  = irq_en;
        bus_write(uart_ctrl_addr_c, w);
    endtask

    task automatic read_status(output bus_word_u w);
        logic [31:0] r;
        bus_read(uart_ctrl_addr_c, r);
        w = r;
    endtask

    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] r;
        int          n;
        n = 0;
        bus_read(uart_ctrl_addr_c, r);
        while ((r & mask) !== value) begin
            n++;
            if (n > tmo_c) abort_on_timeout(what);
            bus_read(uart_ctrl_addr_c, r);
        end
    endtask

    task automatic wait_line(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (line_level(sel) !== level) begin
            next_cycle();
            n++;
            if (n > tmo_c) abort_on_timeout(what);
        end
    endtask

    task automatic read_and_compare(input string name, input logic [7:0] expected);
        logic [31:0] r;
        bus_read(uart_rtx_addr_c, r);
        check(name, {24'h0, expected}, r); // upper bits read zero
    endtask

    // serial line model ------------------------------------------
    task automatic send_frame(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0}; // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            uart_rxd_i = frame[i];
            repeat (bit_cyc_c) next_cycle();
        end
        repeat (bit_cyc_c) next_cycle(); // idle gap before next start
    endtask

    task automatic capture_frame(output logic [7:0] value);
        int n;
        n = 0;
        while (uart_txd_o) begin
            next_cycle();
            n++;
            if (n > tmo_c) abort_on_timeout("start bit on uart_txd_o");
        end
        repeat (bit_cyc_c / 2) next_cycle(); // mid start bit
        check("tx start bit", 0, uart_txd_o);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cyc_c) next_cycle();
            value[i] = uart_txd_o;
        end
        repeat (bit_cyc_c) next_cycle();
        check("tx stop bit", 1, uart_txd_o);
    endtask

    // test sequence ----------------------------------------------
    initial begin
        bus_word_u  w;
        logic       en, hw, held;
        logic [2:0] pr;
        logic [9:0] bd;
        logic [4:0] ie;
        logic [7:0] b, b_exp;
        logic [7:0] tx_bytes [depth_c];
        logic [7:0] rx_bytes [depth_c + 1];

        lfsr       = 32'h7665ff1a;
        errors     = 0;
        checks     = 0;
        addr_i     = '0;
        data_i     = '0;
        rden_i     = 1'b0;
        wren_i     = 1'b0;
        clkgen_i   = 8'hff;  // every tap ticks each cycle
        uart_rxd_i = 1'b1;
        uart_cts_i = 1'b0;
        rstn_i     = 1'b0;
        repeat (4) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        // control register read-back with random fields
        for (int i = 0; i < 8; i++) begin
            en = 1'(rand_bits(1));
            hw = 1'(rand_bits(1));
            pr = 3'(rand_bits(3));
            bd = 10'(rand_bits(10));
            ie = 5'(rand_bits(5));
            write_ctrl(en, hw, pr, bd, ie);
            read_status(w);
            check("ctrl enable", en, w.ctrl.enable);
            check("ctrl hwfc", hw, w.ctrl.hwfc_en);
            check("ctrl prsc", pr, w.ctrl.prsc);
            check("ctrl baud", bd, w.ctrl.baud);
            check("ctrl irq enables", ie, w.ctrl.irq_en);
        end
        write_ctrl(1'b1, 1'b0, 3'd0, baud_c, 5'b00000);
        read_status(w);
        check("status tx_empty", 1, w.ctrl.tx_empty);
        check("status tx_nhalf", 1, w.ctrl.tx_nhalf);
        check("status rx_nempty", 0, w.ctrl.rx_nempty);
        check("status rx_over", 0, w.ctrl.rx_over);

        // transmit, line watched while bytes are queued
        for (int i = 0; i < depth_c; i++) tx_bytes[i] = 8'(rand_bits(8));
        fork
            for (int i = 0; i < depth_c; i++) bus_write(uart_rtx_addr_c, {24'h0, tx_bytes[i]});
            for (int i = 0; i < depth_c; i++) begin
                capture_frame(b);
                check("tx data", tx_bytes[i], b);
            end
        join
        wait_status(m_tx_busy_c, 32'h0, "transmitter idle");

        // receive with the not-empty interrupt
        write_ctrl(1'b1, 1'b0, 3'd0, baud_c, 5'b00001);
        next_cycle(); // irq is registered from the new enables
        check("irq_rx before frames", 0, irq_rx_o);
        for (int i = 0; i < 3; i++) begin
            rx_bytes[i] = 8'(rand_bits(8));
            send_frame(rx_bytes[i]);
            if (i == 0) wait_line(sel_irq_rx_c, 1'b1, "irq_rx_o rise");
        end
        wait_status(m_rx_nempty_c, m_rx_nempty_c, "rx_nempty");
        for (int i = 0; i < 3; i++) read_and_compare("rx data", rx_bytes[i]);
        read_status(w);
        check("rx_nempty after drain", 0, w.ctrl.rx_nempty);
        wait_line(sel_irq_rx_c, 1'b0, "irq_rx_o fall");

        // overrun, one frame more than the fifo holds
        for (int i = 0; i < depth_c + 1; i++) begin
            rx_bytes[i] = 8'(rand_bits(8));
            send_frame(rx_bytes[i]);
        end
        wait_status(m_rx_over_c, m_rx_over_c, "rx overrun flag");
        read_status(w);
        check("rx_full at overrun", 1, w.ctrl.rx_full);
        read_and_compare("overrun data", rx_bytes[0]);
        read_status(w);
        check("rx_over cleared by read", 0, w.ctrl.rx_over);
        for (int i = 1; i < depth_c; i++) read_and_compare("overrun data", rx_bytes[i]);
        read_status(w);
        check("rx_nempty after overrun drain", 0, w.ctrl.rx_nempty);

        // flow control, cts holds the byte and rts follows rx level
        uart_cts_i = 1'b1;   // remote says stop
        write_ctrl(1'b1, 1'b1, 3'd0, baud_c, 5'b00000);
        b_exp = 8'(rand_bits(8));
        bus_write(uart_rtx_addr_c, {24'h0, b_exp});
        held = 1'b1;
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            if (!uart_txd_o) held = 1'b0;
        end
        check("txd held by cts", 1, held);
        uart_cts_i = 1'b0;
        capture_frame(b);
        check("tx data after cts", b_exp, b);
        check("rts with empty rx", 0, uart_rts_o);
        rx_bytes[0] = 8'(rand_bits(8));
        send_frame(rx_bytes[0]);
        check("rts with one rx byte", 0, uart_rts_o); // still below half
        rx_bytes[1] = 8'(rand_bits(8));
        send_frame(rx_bytes[1]);
        wait_line(sel_rts_c, 1'b1, "uart_rts_o rise");
        for (int i = 0; i < 2; i++) read_and_compare("rx data under hwfc", rx_bytes[i]);
        wait_line(sel_rts_c, 1'b0, "uart_rts_o fall");

        // disable with both fifos holding data
        uart_cts_i = 1'b1;   // keep tx bytes queued
        write_ctrl(1'b1, 1'b1, 3'd0, baud_c, 5'b10001);
        send_frame(8'(rand_bits(8)));
        bus_write(uart_rtx_addr_c, {24'h0, 8'(rand_bits(8))});
        bus_write(uart_rtx_addr_c, {24'h0, 8'(rand_bits(8))});
        wait_line(sel_irq_rx_c, 1'b1, "irq_rx_o before disable");
        wait_line(sel_irq_tx_c, 1'b1, "irq_tx_o before disable");
        read_status(w);
        check("tx_empty before disable", 0, w.ctrl.tx_empty);
        check("rx_nempty before disable", 1, w.ctrl.rx_nempty);
        write_ctrl(1'b0, 1'b1, 3'd0, baud_c, 5'b10001);
        check("clkgen_en_o off", 0, clkgen_en_o);
        wait_line(sel_irq_tx_c, 1'b0, "irq_tx_o drop");
        wait_line(sel_irq_rx_c, 1'b0, "irq_rx_o drop");
        read_status(w);
        check("tx_empty while disabled", 1, w.ctrl.tx_empty);
        check("rx_nempty while disabled", 0, w.ctrl.rx_nempty);
        uart_cts_i = 1'b0;
        write_ctrl(1'b1, 1'b0, 3'd0, baud_c, 5'b00000);
        check("clkgen_en_o on", 1, clkgen_en_o);
        read_status(w);
        check("tx_empty after enable", 1, w.ctrl.tx_empty);
        check("tx_nhalf after enable", 1, w.ctrl.tx_nhalf);
        check("rx_nempty after enable", 0, w.ctrl.rx_nempty);
        check("rx_over after enable", 0, w.ctrl.rx_over);
        check("tx_busy after enable", 0, w.ctrl.tx_busy);

        finish_run();
    end

endmodule

//--- src.f
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_status.sv
hdl/uart_top.sv
testbench/tb_uart.sv

//--- Makefile
# Verilator build and run for the UART testbench

TOP             ?= tb_uart
SRC             ?= src.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS      ?= --lint-only --timing -Wall
PASS_MSG        ?= TEST PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRC) $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SRC)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(SRC)

clean:
	rm -rf $(OBJ_DIR)
